// ==== csr_defines.svh ====
// widths, CSR numbers, reset values and address fields of the CSR subsystem; include where used
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath and bus widths
`define XLEN 32
`define NUM_HARTS 4
`define HART_IDX_W 2
`define CSR_NUM_W 12
`define AXI_ADDR_W 32

// enum widths used by csr_pkg
`define CSR_OP_W 3
`define FRONT_ST_W 2

// standard machine-mode CSR numbers
`define CSR_MSTATUS_ADDR 12'h300
`define CSR_MTVEC_ADDR 12'h305
`define CSR_MEPC_ADDR 12'h341
`define CSR_MCAUSE_ADDR 12'h342
`define CSR_MVENDORID_ADDR 12'hF11
`define CSR_MARCHID_ADDR 12'hF12
`define CSR_MHARTID_ADDR 12'hF14

// reset and identity values, mepc/mtvec/mcause come up as zero
`define MSTATUS_RESET 32'h0000_1800
`define MVENDORID_VALUE 32'h7973_7978
`define MARCHID_VALUE 32'd23060025

// host address layout, byte bits 1..0 unused
`define ADDR_CSR_LSB 2
`define ADDR_OP_LSB 14
`define ADDR_OP_W 2
`define ADDR_HART_LSB 16

// AXI response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== csr_pkg.sv ====
// enum types shared by the CSR subsystem RTL and testbench, pulled in with a wildcard import
`include "csr_defines.svh"

package csr_pkg;

	// operation seen by a bank
	// write/set/clear match the address op field encodings 0..2
	// encoding 3 on the bus is turned into rsvd by the front end
	// read never appears on the bus, front end uses it for AR accesses
	typedef enum logic [`CSR_OP_W-1:0] {
		CSR_OP_WRITE = 3'd0,
		CSR_OP_SET   = 3'd1,
		CSR_OP_CLEAR = 3'd2,
		CSR_OP_RSVD  = 3'd3,
		CSR_OP_READ  = 3'd4
	} csr_op_e;

	// front end access sequence
	// idle   waiting for AW+W or AR
	// issue  one-cycle request pulse to the banks
	// wait   collector answer arrives, response already on the bus
	// resp   host back-pressure, response held
	typedef enum logic [`FRONT_ST_W-1:0] {
		ST_IDLE  = 2'd0,
		ST_ISSUE = 2'd1,
		ST_WAIT  = 2'd2,
		ST_RESP  = 2'd3
	} front_state_e;

endpackage

// ==== csr_axil_front.sv ====
// AXI4-Lite slave front end; decodes hart, op and CSR number and pulses one request per access
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_axil_front
	import csr_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	// write address and data channels
	input  logic [`AXI_ADDR_W-1:0]  s_awaddr,
	input  logic                    s_awvalid,
	output logic                    s_awready,
	input  logic [`XLEN-1:0]        s_wdata,
	// strobes not decoded so partial writes act as full words
	input  logic [`XLEN/8-1:0]      s_wstrb,
	input  logic                    s_wvalid,
	output logic                    s_wready,
	// write response
	output logic [1:0]              s_bresp,
	output logic                    s_bvalid,
	input  logic                    s_bready,
	// read channels
	input  logic [`AXI_ADDR_W-1:0]  s_araddr,
	input  logic                    s_arvalid,
	output logic                    s_arready,
	output logic [`XLEN-1:0]        s_rdata,
	output logic [1:0]              s_rresp,
	output logic                    s_rvalid,
	input  logic                    s_rready,
	// request to the banks
	output logic [`NUM_HARTS-1:0]   req_valid,
	output csr_op_e                 req_op,
	output logic [`CSR_NUM_W-1:0]   req_csr,
	output logic [`XLEN-1:0]        req_wdata,
	// answer from the collector
	input  logic                    resp_valid,
	input  logic [`XLEN-1:0]        resp_data,
	input  logic                    resp_err
);

	front_state_e            state_q;
	logic                    is_write_q;
	logic [`HART_IDX_W-1:0]  hart_q;
	csr_op_e                 op_q;
	logic [`CSR_NUM_W-1:0]   csr_q;
	logic [`XLEN-1:0]        wdata_q;
	logic [`XLEN-1:0]        resp_data_q;
	logic                    resp_err_q;

	logic                    wr_go;
	logic                    rd_go;
	logic                    resp_live;
	logic                    resp_taken;
	logic                    out_err;
	logic [`XLEN-1:0]        out_data;

	// bus op field to bank op with encoding 3 as reserved
	function automatic csr_op_e decode_op(input logic [`ADDR_OP_W-1:0] field);
		case (field)
			2'd0:    decode_op = CSR_OP_WRITE;
			2'd1:    decode_op = CSR_OP_SET;
			2'd2:    decode_op = CSR_OP_CLEAR;
			default: decode_op = CSR_OP_RSVD;
		endcase
	endfunction

	// accept only when idle and let a write win over a same-cycle read
	assign wr_go = (state_q == ST_IDLE) && s_awvalid && s_wvalid;
	assign rd_go = (state_q == ST_IDLE) && s_arvalid && !(s_awvalid && s_wvalid);

	assign s_awready = wr_go;
	assign s_wready  = wr_go;
	assign s_arready = rd_go;

	// response is on the bus from the collector pulse until taken
	assign resp_live  = ((state_q == ST_WAIT) && resp_valid) || (state_q == ST_RESP);
	assign resp_taken = is_write_q ? s_bready : s_rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q    <= ST_IDLE;
			is_write_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (wr_go) begin
						state_q    <= ST_ISSUE;
						is_write_q <= 1'b1;
					end else if (rd_go) begin
						state_q    <= ST_ISSUE;
						is_write_q <= 1'b0;
					end
				end
				ST_ISSUE: begin
					state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					// accepted right away or held in resp
					if (resp_valid) begin
						state_q <= resp_taken ? ST_IDLE : ST_RESP;
					end
				end
				ST_RESP: begin
					if (resp_taken) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// access fields captured at the handshake
	always_ff @(posedge clock) begin
		if (wr_go) begin
			hart_q  <= s_awaddr[`ADDR_HART_LSB +: `HART_IDX_W];
			csr_q   <= s_awaddr[`ADDR_CSR_LSB +: `CSR_NUM_W];
			op_q    <= decode_op(s_awaddr[`ADDR_OP_LSB +: `ADDR_OP_W]);
			wdata_q <= s_wdata;
		end else if (rd_go) begin
			// op field of a read address is ignored
			hart_q <= s_araddr[`ADDR_HART_LSB +: `HART_IDX_W];
			csr_q  <= s_araddr[`ADDR_CSR_LSB +: `CSR_NUM_W];
			op_q   <= CSR_OP_READ;
		end
		// keep the answer for back-pressure
		if ((state_q == ST_WAIT) && resp_valid) begin
			resp_data_q <= resp_data;
			resp_err_q  <= resp_err;
		end
	end

	// live collector answer in wait and the held copy afterwards
	assign out_data = (state_q == ST_RESP) ? resp_data_q : resp_data;
	assign out_err  = (state_q == ST_RESP) ? resp_err_q : resp_err;

	assign s_bvalid = resp_live && is_write_q;
	assign s_bresp  = out_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
	assign s_rvalid = resp_live && !is_write_q;
	assign s_rresp  = out_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
	assign s_rdata  = out_data;

	// one-hot request to the addressed hart in the issue cycle only
	always_comb begin
		req_valid = '0;
		if (state_q == ST_ISSUE) begin
			req_valid[hart_q] = 1'b1;
		end
	end

	assign req_op    = op_q;
	assign req_csr   = csr_q;
	assign req_wdata = wdata_q;

	// each accepted access gives exactly one single-hart pulse in the next cycle
	a_req_pulse: assert property (@(posedge clock) disable iff (reset)
		(wr_go || rd_go) |=> $onehot(req_valid) ##1 (req_valid == '0));

	// write response held with stable code until the host takes it
	a_b_hold: assert property (@(posedge clock) disable iff (reset)
		(s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bresp)));

endmodule

// ==== csr_file.sv ====
// one hart's machine-mode CSR bank; answers a front end request and captures traps
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_file
	import csr_pkg::*;
#(
	parameter int unsigned HART_ID = 0
) (
	input  logic                   clock,
	input  logic                   reset,
	// one-cycle request, shared op/csr/data
	input  logic                   req_valid,
	input  csr_op_e                req_op,
	input  logic [`CSR_NUM_W-1:0]  req_csr,
	input  logic [`XLEN-1:0]       req_wdata,
	// trap capture for this hart
	input  logic                   trap_valid,
	input  logic [`XLEN-1:0]       trap_cause,
	input  logic [`XLEN-1:0]       trap_pc,
	// combinational answer in the request cycle
	output logic [`XLEN-1:0]       rd_data,
	output logic                   illegal
);

	logic [`XLEN-1:0] mstatus_q;
	logic [`XLEN-1:0] mepc_q;
	logic [`XLEN-1:0] mtvec_q;
	logic [`XLEN-1:0] mcause_q;
	logic [`XLEN-1:0] mhartid;

	logic             sel_mstatus;
	logic             sel_mepc;
	logic             sel_mtvec;
	logic             sel_mcause;
	logic             sel_mvendorid;
	logic             sel_marchid;
	logic             sel_mhartid;

	logic             is_read_only;
	logic             is_known;
	logic             is_write_op;
	logic             commit;
	logic [`XLEN-1:0] new_value;

	assign mhartid = HART_ID[`XLEN-1:0];

	// single decode of the CSR number
	assign sel_mstatus   = (req_csr == `CSR_MSTATUS_ADDR);
	assign sel_mepc      = (req_csr == `CSR_MEPC_ADDR);
	assign sel_mtvec     = (req_csr == `CSR_MTVEC_ADDR);
	assign sel_mcause    = (req_csr == `CSR_MCAUSE_ADDR);
	assign sel_mvendorid = (req_csr == `CSR_MVENDORID_ADDR);
	assign sel_marchid   = (req_csr == `CSR_MARCHID_ADDR);
	assign sel_mhartid   = (req_csr == `CSR_MHARTID_ADDR);

	assign is_read_only = sel_mvendorid | sel_marchid | sel_mhartid;
	assign is_known     = sel_mstatus | sel_mepc | sel_mtvec | sel_mcause | is_read_only;

	assign is_write_op = (req_op == CSR_OP_WRITE)
		|| (req_op == CSR_OP_SET)
		|| (req_op == CSR_OP_CLEAR);

	// old value, zero for an unknown number
	assign rd_data = ({`XLEN{sel_mstatus}} & mstatus_q)
		| ({`XLEN{sel_mepc}} & mepc_q)
		| ({`XLEN{sel_mtvec}} & mtvec_q)
		| ({`XLEN{sel_mcause}} & mcause_q)
		| ({`XLEN{sel_mvendorid}} & `MVENDORID_VALUE)
		| ({`XLEN{sel_marchid}} & `MARCHID_VALUE)
		| ({`XLEN{sel_mhartid}} & mhartid);

	// unknown number, write to identity CSR, or reserved op
	assign illegal = !is_known
		|| (is_read_only && is_write_op)
		|| (req_op == CSR_OP_RSVD);

	// read-modify-write value
	always_comb begin
		case (req_op)
			CSR_OP_SET:   new_value = rd_data | req_wdata;
			CSR_OP_CLEAR: new_value = rd_data & ~req_wdata;
			default:      new_value = req_wdata;
		endcase
	end

	assign commit = req_valid && is_write_op && !illegal;

	// bus-only registers
	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus_q <= `MSTATUS_RESET;
			mtvec_q   <= '0;
		end else if (commit) begin
			if (sel_mstatus) begin
				mstatus_q <= new_value;
			end
			if (sel_mtvec) begin
				mtvec_q <= new_value;
			end
		end
	end

	// trap path, beats a same-cycle bus write
	always_ff @(posedge clock) begin
		if (reset) begin
			mepc_q   <= '0;
			mcause_q <= '0;
		end else if (trap_valid) begin
			mepc_q   <= trap_pc;
			mcause_q <= trap_cause;
		end else if (commit) begin
			if (sel_mepc) begin
				mepc_q <= new_value;
			end
			if (sel_mcause) begin
				mcause_q <= new_value;
			end
		end
	end

	// rejected request leaves state alone, only a trap may move mepc/mcause
	a_illegal_no_update: assert property (@(posedge clock) disable iff (reset)
		(req_valid && illegal) |=> ($stable(mstatus_q) && $stable(mtvec_q)
			&& ($past(trap_valid) || ($stable(mepc_q) && $stable(mcause_q)))));

endmodule

// ==== csr_resp_collect.sv ====
// response collector; picks the addressed bank's answer and registers it as a one-cycle pulse
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_resp_collect (
	input  logic                              clock,
	input  logic                              reset,
	// request pulse, one bit per hart
	input  logic [`NUM_HARTS-1:0]             req_valid,
	// combinational bank answers
	input  logic [`NUM_HARTS-1:0][`XLEN-1:0]  rd_data,
	input  logic [`NUM_HARTS-1:0]             illegal,
	// to the front end, one cycle after the request
	output logic                              resp_valid,
	output logic [`XLEN-1:0]                  resp_data,
	output logic                              resp_err
);

	logic [`XLEN-1:0] sel_data;
	logic             sel_err;

	// and-or select on the request bits
	always_comb begin
		sel_data = '0;
		sel_err  = 1'b0;
		for (int i = 0; i < `NUM_HARTS; i++) begin
			if (req_valid[i]) begin
				sel_data = sel_data | rd_data[i];
				sel_err  = sel_err | illegal[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= |req_valid;
		end
	end

	// data and error stay put between requests
	always_ff @(posedge clock) begin
		if (|req_valid) begin
			resp_data <= sel_data;
			resp_err  <= sel_err;
		end
	end

	// the and-or select only works for a single addressed hart
	a_one_req: assert property (@(posedge clock) disable iff (reset)
		$onehot0(req_valid));

endmodule

// ==== csr_subsys_top.sv ====
// top of the multi-hart CSR subsystem; host AXI4-Lite port plus per-hart trap inputs
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_subsys_top
	import csr_pkg::*;
(
	input  logic                              clock,
	input  logic                              reset,
	// AXI4-Lite slave
	input  logic [`AXI_ADDR_W-1:0]            s_awaddr,
	input  logic                              s_awvalid,
	output logic                              s_awready,
	input  logic [`XLEN-1:0]                  s_wdata,
	input  logic [`XLEN/8-1:0]                s_wstrb,
	input  logic                              s_wvalid,
	output logic                              s_wready,
	output logic [1:0]                        s_bresp,
	output logic                              s_bvalid,
	input  logic                              s_bready,
	input  logic [`AXI_ADDR_W-1:0]            s_araddr,
	input  logic                              s_arvalid,
	output logic                              s_arready,
	output logic [`XLEN-1:0]                  s_rdata,
	output logic [1:0]                        s_rresp,
	output logic                              s_rvalid,
	input  logic                              s_rready,
	// traps, one slice per hart
	input  logic [`NUM_HARTS-1:0]             trap_valid,
	input  logic [`NUM_HARTS-1:0][`XLEN-1:0]  trap_cause,
	input  logic [`NUM_HARTS-1:0][`XLEN-1:0]  trap_pc
);

	// front end to banks
	logic [`NUM_HARTS-1:0]             req_valid;
	csr_op_e                           req_op;
	logic [`CSR_NUM_W-1:0]             req_csr;
	logic [`XLEN-1:0]                  req_wdata;
	// banks to collector
	logic [`NUM_HARTS-1:0][`XLEN-1:0]  rd_data;
	logic [`NUM_HARTS-1:0]             illegal;
	// collector to front end
	logic                              resp_valid;
	logic [`XLEN-1:0]                  resp_data;
	logic                              resp_err;

	csr_axil_front i_front (
		.clock      (clock),
		.reset      (reset),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_araddr   (s_araddr),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_csr    (req_csr),
		.req_wdata  (req_wdata),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_err   (resp_err)
	);

	// one bank per hart, mhartid from the loop index
	for (genvar i = 0; i < `NUM_HARTS; i++) begin : g_hart
		csr_file #(
			.HART_ID (i)
		) i_csr_file (
			.clock      (clock),
			.reset      (reset),
			.req_valid  (req_valid[i]),
			.req_op     (req_op),
			.req_csr    (req_csr),
			.req_wdata  (req_wdata),
			.trap_valid (trap_valid[i]),
			.trap_cause (trap_cause[i]),
			.trap_pc    (trap_pc[i]),
			.rd_data    (rd_data[i]),
			.illegal    (illegal[i])
		);
	end

	csr_resp_collect i_collect (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.rd_data    (rd_data),
		.illegal    (illegal),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_err   (resp_err)
	);

endmodule

// ==== tb_csr_subsys.sv ====
// self-checking testbench for csr_subsys_top; runs a table of bus accesses and traps
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_subsys
	import csr_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 50;
	localparam int MAX_STALL = 5;

	typedef enum logic [1:0] {
		KIND_WRITE,
		KIND_READ,
		KIND_TRAP
	} kind_e;

	// one table row; trap fields also used by a write that meets a trap
	typedef struct {
		kind_e                 kind;
		int unsigned           hart;
		csr_op_e               op;
		logic [`CSR_NUM_W-1:0] csr;
		logic [`XLEN-1:0]      data;
		logic [`XLEN-1:0]      exp_data;
		logic [1:0]            exp_resp;
		logic                  trap_now;
		logic [`XLEN-1:0]      trap_cause;
		logic [`XLEN-1:0]      trap_pc;
	} entry_t;

	logic                              clock;
	logic                              reset;
	logic [`AXI_ADDR_W-1:0]            s_awaddr;
	logic                              s_awvalid;
	logic                              s_awready;
	logic [`XLEN-1:0]                  s_wdata;
	logic [`XLEN/8-1:0]                s_wstrb;
	logic                              s_wvalid;
	logic                              s_wready;
	logic [1:0]                        s_bresp;
	logic                              s_bvalid;
	logic                              s_bready;
	logic [`AXI_ADDR_W-1:0]            s_araddr;
	logic                              s_arvalid;
	logic                              s_arready;
	logic [`XLEN-1:0]                  s_rdata;
	logic [1:0]                        s_rresp;
	logic                              s_rvalid;
	logic                              s_rready;
	logic [`NUM_HARTS-1:0]             trap_valid;
	logic [`NUM_HARTS-1:0][`XLEN-1:0]  trap_cause;
	logic [`NUM_HARTS-1:0][`XLEN-1:0]  trap_pc;

	entry_t stim_q[$];
	integer seed = 32'h2095;
	int     cur_idx;
	int     check_count;
	int     err_count;
	int     timeout_count;

	csr_subsys_top i_dut (
		.clock      (clock),
		.reset      (reset),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_araddr   (s_araddr),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.trap_valid (trap_valid),
		.trap_cause (trap_cause),
		.trap_pc    (trap_pc)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	// bus op field encoding of the host address
	function automatic logic [`ADDR_OP_W-1:0] op_field(input csr_op_e op);
		case (op)
			CSR_OP_WRITE: op_field = 2'd0;
			CSR_OP_SET:   op_field = 2'd1;
			CSR_OP_CLEAR: op_field = 2'd2;
			default:      op_field = 2'd3;
		endcase
	endfunction

	function automatic logic [`AXI_ADDR_W-1:0] make_addr(input int unsigned hart,
		input logic [`ADDR_OP_W-1:0] op, input logic [`CSR_NUM_W-1:0] csr);
		logic [`AXI_ADDR_W-1:0] a;
		a = '0;
		a[`ADDR_HART_LSB +: `HART_IDX_W] = hart[`HART_IDX_W-1:0];
		a[`ADDR_OP_LSB +: `ADDR_OP_W] = op;
		a[`ADDR_CSR_LSB +: `CSR_NUM_W] = csr;
		make_addr = a;
	endfunction

	task automatic check_word(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("[ERROR] entry %0d %s got 0x%0h expected 0x%0h", cur_idx, name, got, exp);
		end
	endtask

	task automatic add_write(input int unsigned hart, input csr_op_e op,
		input logic [`CSR_NUM_W-1:0] csr, input logic [`XLEN-1:0] data, input logic [1:0] resp);
		entry_t e;
		e = '{KIND_WRITE, hart, op, csr, data, '0, resp, 1'b0, '0, '0};
		stim_q.push_back(e);
	endtask

	// op field is a don't-care on reads, send the reserved code
	task automatic add_read(input int unsigned hart, input logic [`CSR_NUM_W-1:0] csr,
		input logic [`XLEN-1:0] exp, input logic [1:0] resp);
		entry_t e;
		e = '{KIND_READ, hart, CSR_OP_RSVD, csr, '0, exp, resp, 1'b0, '0, '0};
		stim_q.push_back(e);
	endtask

	task automatic add_trap(input int unsigned hart, input logic [`XLEN-1:0] cause,
		input logic [`XLEN-1:0] pc);
		entry_t e;
		e = '{KIND_TRAP, hart, CSR_OP_WRITE, '0, '0, '0, '0, 1'b1, cause, pc};
		stim_q.push_back(e);
	endtask

	// bus write whose request cycle is also the trap sample
	task automatic add_write_trap(input int unsigned hart, input logic [`CSR_NUM_W-1:0] csr,
		input logic [`XLEN-1:0] data, input logic [`XLEN-1:0] cause, input logic [`XLEN-1:0] pc);
		entry_t e;
		e = '{KIND_WRITE, hart, CSR_OP_WRITE, csr, data, '0, `AXI_RESP_OKAY, 1'b1, cause, pc};
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		// reset state of every hart
		for (int h = 0; h < `NUM_HARTS; h++) begin
			add_read(h, `CSR_MSTATUS_ADDR, `MSTATUS_RESET, `AXI_RESP_OKAY);
			add_read(h, `CSR_MVENDORID_ADDR, `MVENDORID_VALUE, `AXI_RESP_OKAY);
			add_read(h, `CSR_MARCHID_ADDR, `MARCHID_VALUE, `AXI_RESP_OKAY);
			add_read(h, `CSR_MHARTID_ADDR, h, `AXI_RESP_OKAY);
			add_read(h, `CSR_MEPC_ADDR, 32'h0, `AXI_RESP_OKAY);
			add_read(h, `CSR_MTVEC_ADDR, 32'h0, `AXI_RESP_OKAY);
			add_read(h, `CSR_MCAUSE_ADDR, 32'h0, `AXI_RESP_OKAY);
		end
		// write, set, clear on hart 1
		add_write(1, CSR_OP_WRITE, `CSR_MTVEC_ADDR, 32'h8000_0100, `AXI_RESP_OKAY);
		add_read(1, `CSR_MTVEC_ADDR, 32'h8000_0100, `AXI_RESP_OKAY);
		add_write(1, CSR_OP_SET, `CSR_MTVEC_ADDR, 32'h0000_0003, `AXI_RESP_OKAY);
		add_read(1, `CSR_MTVEC_ADDR, 32'h8000_0103, `AXI_RESP_OKAY);
		add_write(1, CSR_OP_CLEAR, `CSR_MTVEC_ADDR, 32'h8000_0001, `AXI_RESP_OKAY);
		add_read(1, `CSR_MTVEC_ADDR, 32'h0000_0102, `AXI_RESP_OKAY);
		add_write(1, CSR_OP_WRITE, `CSR_MSTATUS_ADDR, 32'h0000_0088, `AXI_RESP_OKAY);
		add_read(1, `CSR_MSTATUS_ADDR, 32'h0000_0088, `AXI_RESP_OKAY);
		add_write(1, CSR_OP_SET, `CSR_MSTATUS_ADDR, 32'h0000_1800, `AXI_RESP_OKAY);
		add_read(1, `CSR_MSTATUS_ADDR, 32'h0000_1888, `AXI_RESP_OKAY);
		add_write(1, CSR_OP_CLEAR, `CSR_MSTATUS_ADDR, 32'h0000_0008, `AXI_RESP_OKAY);
		add_read(1, `CSR_MSTATUS_ADDR, 32'h0000_1880, `AXI_RESP_OKAY);
		// other harts untouched
		add_read(0, `CSR_MTVEC_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_read(2, `CSR_MSTATUS_ADDR, `MSTATUS_RESET, `AXI_RESP_OKAY);
		add_read(3, `CSR_MTVEC_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_write(2, CSR_OP_WRITE, `CSR_MEPC_ADDR, 32'h1234_5678, `AXI_RESP_OKAY);
		add_read(2, `CSR_MEPC_ADDR, 32'h1234_5678, `AXI_RESP_OKAY);
		add_read(0, `CSR_MEPC_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_read(1, `CSR_MEPC_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_read(3, `CSR_MEPC_ADDR, 32'h0, `AXI_RESP_OKAY);
		// rejected accesses, unknown number reads as zero
		add_write(0, CSR_OP_WRITE, 12'h7C0, 32'hFFFF_FFFF, `AXI_RESP_SLVERR);
		add_read(0, 12'h7C0, 32'h0, `AXI_RESP_SLVERR);
		add_write(0, CSR_OP_WRITE, `CSR_MVENDORID_ADDR, 32'h0, `AXI_RESP_SLVERR);
		add_read(0, `CSR_MVENDORID_ADDR, `MVENDORID_VALUE, `AXI_RESP_OKAY);
		add_write(3, CSR_OP_SET, `CSR_MHARTID_ADDR, 32'h0000_00F0, `AXI_RESP_SLVERR);
		add_read(3, `CSR_MHARTID_ADDR, 32'd3, `AXI_RESP_OKAY);
		add_write(2, CSR_OP_RSVD, `CSR_MTVEC_ADDR, 32'hDEAD_BEEF, `AXI_RESP_SLVERR);
		add_read(2, `CSR_MTVEC_ADDR, 32'h0, `AXI_RESP_OKAY);
		// trap on hart 3 only
		add_trap(3, 32'h0000_000B, 32'h8000_2000);
		add_read(3, `CSR_MCAUSE_ADDR, 32'h0000_000B, `AXI_RESP_OKAY);
		add_read(3, `CSR_MEPC_ADDR, 32'h8000_2000, `AXI_RESP_OKAY);
		add_read(0, `CSR_MCAUSE_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_read(1, `CSR_MCAUSE_ADDR, 32'h0, `AXI_RESP_OKAY);
		add_read(2, `CSR_MEPC_ADDR, 32'h1234_5678, `AXI_RESP_OKAY);
		// trap wins over the bus write in the same cycle
		add_write_trap(0, `CSR_MEPC_ADDR, 32'h1111_1110, 32'h0000_0007, 32'h8000_3000);
		add_read(0, `CSR_MEPC_ADDR, 32'h8000_3000, `AXI_RESP_OKAY);
		add_read(0, `CSR_MCAUSE_ADDR, 32'h0000_0007, `AXI_RESP_OKAY);
		add_read(2, `CSR_MTVEC_ADDR, 32'h0, `AXI_RESP_OKAY);
	endtask

	task automatic set_ready(input logic is_write, input logic value);
		if (is_write) begin
			s_bready <= value;
		end else begin
			s_rready <= value;
		end
	endtask

	// waits for b or r valid, stalls a random number of cycles, then accepts
	task automatic take_response(input logic is_write, output logic [1:0] resp,
		output logic [`XLEN-1:0] data);
		int   cycles;
		int   stall;
		logic seen;
		string vname;
		string rname;
		cycles = 0;
		seen = 1'b0;
		vname = is_write ? "s_bvalid" : "s_rvalid";
		rname = is_write ? "s_bresp" : "s_rresp";
		stall = $unsigned($random(seed)) % (MAX_STALL + 1);
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			seen = is_write ? s_bvalid : s_rvalid;
			cycles++;
		end
		if (!seen) begin
			timeout_count++;
			$display("timeout: no response came back for entry %0d", cur_idx);
			resp = 2'b11;
			data = '0;
		end else begin
			resp = is_write ? s_bresp : s_rresp;
			data = s_rdata;
			// response must hold while ready is low
			repeat (stall) begin
				@(negedge clock);
				check_word(vname, is_write ? s_bvalid : s_rvalid, 1'b1);
				check_word(rname, is_write ? s_bresp : s_rresp, resp);
				if (!is_write) begin
					check_word("s_rdata", s_rdata, data);
				end
			end
			@(posedge clock);
			set_ready(is_write, 1'b1);
			@(negedge clock);
			check_word(vname, is_write ? s_bvalid : s_rvalid, 1'b1);
			@(posedge clock);
			set_ready(is_write, 1'b0);
			// valid drops once taken
			@(negedge clock);
			check_word(vname, is_write ? s_bvalid : s_rvalid, 1'b0);
		end
	endtask

	task automatic do_write(input entry_t e);
		logic [1:0]       resp;
		logic [`XLEN-1:0] data;
		int               cycles;
		logic             accepted;
		cycles = 0;
		accepted = 1'b0;
		@(posedge clock);
		s_awaddr <= make_addr(e.hart, op_field(e.op), e.csr);
		s_wdata <= e.data;
		s_wstrb <= '1;
		s_awvalid <= 1'b1;
		s_wvalid <= 1'b1;
		while (!accepted && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			accepted = s_awready && s_wready;
			cycles++;
		end
		if (!accepted) begin
			timeout_count++;
			$display("timeout: write for entry %0d was never accepted", cur_idx);
		end else begin
			// handshake edge, trap lines up with the request cycle
			@(posedge clock);
			s_awvalid <= 1'b0;
			s_wvalid <= 1'b0;
			if (e.trap_now) begin
				trap_valid[e.hart] <= 1'b1;
				trap_cause[e.hart] <= e.trap_cause;
				trap_pc[e.hart] <= e.trap_pc;
				@(posedge clock);
				trap_valid <= '0;
			end
			take_response(1'b1, resp, data);
			check_word("s_bresp", resp, e.exp_resp);
		end
	endtask

	task automatic do_read(input entry_t e);
		logic [1:0]       resp;
		logic [`XLEN-1:0] data;
		int               cycles;
		logic             accepted;
		cycles = 0;
		accepted = 1'b0;
		@(posedge clock);
		s_araddr <= make_addr(e.hart, op_field(e.op), e.csr);
		s_arvalid <= 1'b1;
		while (!accepted && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			accepted = s_arready;
			cycles++;
		end
		if (!accepted) begin
			timeout_count++;
			$display("timeout: read for entry %0d was never accepted", cur_idx);
		end else begin
			@(posedge clock);
			s_arvalid <= 1'b0;
			take_response(1'b0, resp, data);
			check_word("s_rresp", resp, e.exp_resp);
			check_word("s_rdata", data, e.exp_data);
		end
	endtask

	// single-cycle trap pulse, then one idle cycle
	task automatic do_trap(input entry_t e);
		@(posedge clock);
		trap_valid[e.hart] <= 1'b1;
		trap_cause[e.hart] <= e.trap_cause;
		trap_pc[e.hart] <= e.trap_pc;
		@(posedge clock);
		trap_valid <= '0;
		@(posedge clock);
	endtask

	initial begin
		entry_t e;
		reset = 1'b1;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		trap_valid = '0;
		trap_cause = '0;
		trap_pc = '0;
		cur_idx = -1;
		check_count = 0;
		err_count = 0;
		timeout_count = 0;
		build_table();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		// nothing pending right out of reset
		@(negedge clock);
		check_word("s_bvalid", s_bvalid, 1'b0);
		check_word("s_rvalid", s_rvalid, 1'b0);
		for (int i = 0; i < stim_q.size(); i++) begin
			e = stim_q[i];
			cur_idx = i;
			case (e.kind)
				KIND_WRITE: do_write(e);
				KIND_READ:  do_read(e);
				default:    do_trap(e);
			endcase
			if (timeout_count != 0) begin
				break;
			end
		end
		$display("checks %0d, value errors %0d, timeouts %0d",
			check_count, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
csr_pkg.sv
csr_axil_front.sv
csr_file.sv
csr_resp_collect.sv
csr_subsys_top.sv
tb_csr_subsys.sv

// ==== Bender.yml ====
package:
  name: csr_subsys

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - csr_axil_front.sv
      - csr_file.sv
      - csr_resp_collect.sv
      - csr_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_subsys.sv
